// File: common/snd_params.svh
`ifndef SND_PARAMS_SVH
`define SND_PARAMS_SVH

// Program ROM
`define SND_ROM_AW      19
`define SND_BANK_BASE   19'h10000
`define SND_PCM_BASE    19'h60000

// I/O port codes on address bits 7:6
`define SND_IO_FM       2'd0
`define SND_IO_MISC     2'd1
`define SND_IO_PCM      2'd2
`define SND_IO_MAPPER   2'd3

// Mixer gains in 4.4 fixed point
`define SND_FM_GAIN     8'h08
`define SND_PCM_GAIN0   8'h02
`define SND_PCM_GAIN1   8'h04
`define SND_PCM_GAIN2   8'h08
`define SND_PCM_GAIN3   8'h14

`endif

// File: common/snd_pkg.sv
`include "snd_params.svh"

package snd_pkg;

    // Program ROM bank layouts, chosen per game
    typedef enum logic [1:0] {
        BANK_LINEAR = 2'd0,  // 5521 and 5704
        BANK_SWAP   = 2'd1,  // 5797
        BANK_ONEHOT = 2'd2   // 5358
    } bank_mode_t;

    // Device currently addressed on the sound CPU bus
    typedef enum logic [2:0] {
        DEV_NONE   = 3'd0,
        DEV_ROM    = 3'd1,
        DEV_BANK   = 3'd2,
        DEV_FM     = 3'd3,
        DEV_MISC   = 3'd4,
        DEV_PCM    = 3'd5,
        DEV_MAPPER = 3'd6
    } dev_sel_t;

    // One requester's view of the shared ROM port
    typedef struct packed {
        logic                   req;
        logic [`SND_ROM_AW-1:0] addr;
    } rom_req_t;

endpackage

// File: design/snd_decoder.sv
`timescale 1ns/1ps
`include "snd_params.svh"

module snd_decoder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [15:0]          addr,
    input  logic                 mreq_n,
    input  logic                 iorq_n,
    input  logic                 m1_n,
    input  logic                 rd_n,
    input  logic                 wr_n,
    input  logic [7:0]           cpu_dout,
    input  logic [7:0]           game_id,
    input  logic [7:0]           mapper_dout,
    input  logic                 pcm_busy_n,
    input  logic [7:0]           rom_data,
    input  logic                 cpu_rom_grant_ok,
    output logic [7:0]           cpu_din,
    output snd_pkg::rom_req_t    cpu_rom_req,
    output logic                 cpu_rom_ok,
    output logic                 mapper_rd,
    output logic                 mapper_wr,
    output logic [7:0]           mapper_din,
    output logic                 fm_cs,
    output logic                 fm_a0,
    output logic                 pcm_cs,
    output logic                 pcm_rst,
    output logic                 pcm_mdn
);
    import snd_pkg::*;

    logic                   rom_sel, bank_sel, fm_sel, misc_sel, pcm_sel, mapper_sel;
    logic                   rom_rd;
    logic                   rom_done;
    logic [5:0]             bank_bits;
    logic [`SND_ROM_AW-1:0] rom_addr_c;
    bank_mode_t             bank_mode;
    dev_sel_t               dev;

    // Memory map
    assign rom_sel  = !mreq_n && !addr[15];
    assign bank_sel = !mreq_n && addr[15:12] >= 4'h8 && addr[15:12] < 4'he;
    assign rom_rd   = (rom_sel || bank_sel) && !rd_n;

    always_comb begin
        {fm_sel, misc_sel, pcm_sel, mapper_sel} = 4'b0000;
        if (!iorq_n && m1_n) begin
            case (addr[7:6])
                `SND_IO_FM:   fm_sel   = 1'b1;
                `SND_IO_MISC: misc_sel = 1'b1;
                `SND_IO_PCM:  pcm_sel  = 1'b1;
                default:      mapper_sel = 1'b1;
            endcase
        end else begin
            mapper_sel = !mreq_n && addr[15:11] == 5'b11101;  // 0xE800 window
        end
    end

    always_comb begin
        dev = DEV_NONE;
        if (rom_sel)         dev = DEV_ROM;
        else if (bank_sel)   dev = DEV_BANK;
        else if (fm_sel)     dev = DEV_FM;
        else if (misc_sel)   dev = DEV_MISC;
        else if (pcm_sel)    dev = DEV_PCM;
        else if (mapper_sel) dev = DEV_MAPPER;
    end

    always_comb begin
        casez (game_id[7:3])
            5'b001??: bank_mode = BANK_SWAP;
            5'b0001?: bank_mode = BANK_ONEHOT;
            default:  bank_mode = BANK_LINEAR;
        endcase
    end

    // Banked address replaces upper fields of the CPU address
    always_comb begin
        rom_addr_c = {4'd0, addr[14:0]};
        if (bank_sel) begin
            case (bank_mode)
                BANK_SWAP: rom_addr_c[18:14] = {bank_bits[3], bank_bits[4], bank_bits[2:0]};
                BANK_ONEHOT: begin
                    rom_addr_c[15:14] = bank_bits[1:0];
                    case (~bank_bits[5:2])  // One ROM chip enable per socket
                        4'b1000: rom_addr_c[17:16] = 2'd3;
                        4'b0100: rom_addr_c[17:16] = 2'd2;
                        4'b0010: rom_addr_c[17:16] = 2'd1;
                        default: rom_addr_c[17:16] = 2'd0;
                    endcase
                end
                default: rom_addr_c[17:14] = bank_bits[3:0];
            endcase
            rom_addr_c = rom_addr_c + `SND_BANK_BASE;
        end
    end

    assign cpu_rom_req = '{req: rom_rd && !rom_done, addr: rom_addr_c};
    assign cpu_rom_ok  = rom_done;

    // Byte stays valid until the CPU drops the access
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rom_done <= 1'b0;
        end else if (!rom_rd) begin
            rom_done <= 1'b0;
        end else if (cpu_rom_grant_ok) begin
            rom_done <= 1'b1;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bank_bits <= 6'd0;
            pcm_rst   <= 1'b1;
            pcm_mdn   <= 1'b1;
        end else if (misc_sel && !wr_n) begin
            bank_bits <= cpu_dout[5:0];
            pcm_rst   <= ~cpu_dout[6];
            pcm_mdn   <= ~cpu_dout[7];  // Latched mode, player runs as slave
        end
    end

    always_ff @(posedge clk) begin
        case (dev)
            DEV_ROM, DEV_BANK: begin
                if (cpu_rom_grant_ok) cpu_din <= rom_data;
            end
            DEV_PCM:    cpu_din <= {pcm_busy_n, 7'h7f};
            DEV_MAPPER: cpu_din <= mapper_dout;
            default:    cpu_din <= 8'hff;  // FM, misc and unmapped
        endcase
    end

    assign mapper_rd  = mapper_sel && !rd_n;
    assign mapper_wr  = mapper_sel && !wr_n;
    assign mapper_din = cpu_dout;
    assign fm_cs      = fm_sel;
    assign fm_a0      = addr[0];
    assign pcm_cs     = pcm_sel;

    a_one_device: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_sel, bank_sel, fm_sel, misc_sel, pcm_sel, mapper_sel}));

endmodule

// File: design/rom_arbiter.sv
`timescale 1ns/1ps
`include "snd_params.svh"

module rom_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  snd_pkg::rom_req_t      cpu_req,
    input  snd_pkg::rom_req_t      pcm_req,
    input  logic [7:0]             rom_data,
    input  logic                   rom_ok,
    output logic                   rom_cs,
    output logic [`SND_ROM_AW-1:0] rom_addr,
    output logic                   cpu_ok,
    output logic                   pcm_ok
);

    typedef enum logic [1:0] {
        OWN_IDLE = 2'd0,
        OWN_CPU  = 2'd1,
        OWN_PCM  = 2'd2
    } owner_t;

    owner_t owner;
    logic   ok_d;
    logic   confirmed;

    // Data counts only after two consecutive ok cycles
    assign confirmed = rom_ok && ok_d;
    assign rom_cs    = owner != OWN_IDLE;
    assign cpu_ok    = owner == OWN_CPU && confirmed;
    assign pcm_ok    = owner == OWN_PCM && confirmed;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            owner <= OWN_IDLE;
            ok_d  <= 1'b0;
        end else begin
            ok_d <= rom_cs && rom_ok && !confirmed;
            case (owner)
                OWN_IDLE: begin
                    if (cpu_req.req)      owner <= OWN_CPU;  // CPU first
                    else if (pcm_req.req) owner <= OWN_PCM;
                end
                default: begin
                    if (confirmed) owner <= OWN_IDLE;
                end
            endcase
        end
    end

    // Address captured at grant and held for the whole access
    always_ff @(posedge clk) begin
        if (owner == OWN_IDLE) begin
            rom_addr <= cpu_req.req ? cpu_req.addr : pcm_req.addr;
        end
    end

    a_ok_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(cpu_ok && pcm_ok));

    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        rom_cs |=> (!rom_cs || $stable(rom_addr)));

    a_data_known: assert property (@(posedge clk) disable iff (rst)
        confirmed && rom_cs |-> !$isunknown(rom_data));

endmodule

// File: pcm/pcm_player.sv
`timescale 1ns/1ps
`include "snd_params.svh"

module pcm_player (
    input  logic                clk,
    input  logic                rst,
    input  logic                pcm_rst,
    input  logic                cen_pcm,
    input  logic                cs,
    input  logic                wr_n,
    input  logic [7:0]          din,
    input  logic [7:0]          rom_data,
    input  logic                rom_ok,
    output snd_pkg::rom_req_t   rom_req,
    output logic                busy_n,
    output logic signed [7:0]   sample
);

    logic                   playing;
    logic                   pending;
    logic                   wr_d;
    logic                   start;
    logic [`SND_ROM_AW-1:0] ptr;

    // One start per write strobe, however long it is held
    assign start   = cs && !wr_n && !wr_d;
    assign busy_n  = !playing;
    assign rom_req = '{req: pending, addr: ptr};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wr_d <= 1'b0;
        end else begin
            wr_d <= cs && !wr_n;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            playing <= 1'b0;
            pending <= 1'b0;
            sample  <= 8'sd0;
        end else if (pcm_rst) begin
            playing <= 1'b0;
            pending <= 1'b0;
            sample  <= 8'sd0;
        end else begin
            if (start) begin
                playing <= 1'b1;
            end else if (playing && cen_pcm && !pending) begin
                pending <= 1'b1;  // A late fetch keeps the old sample
            end
            if (pending && rom_ok) begin
                pending <= 1'b0;
                if (rom_data == 8'h00) begin
                    playing <= 1'b0;  // End marker
                    sample  <= 8'sd0;
                end else begin
                    sample  <= {~rom_data[7], rom_data[6:0]};  // Offset binary to signed
                end
            end
        end
    end

    // Sample n lives at base + n * 256
    always_ff @(posedge clk) begin
        if (start && !pcm_rst) begin
            ptr <= `SND_PCM_BASE + {3'd0, din, 8'h00};
        end else if (pending && rom_ok) begin
            ptr <= ptr + 1'b1;
        end
    end

endmodule

// File: design/snd_mixer.sv
`timescale 1ns/1ps
`include "snd_params.svh"

module snd_mixer (
    input  logic                clk,
    input  logic                rst,
    input  logic                fm_sample,
    input  logic [15:0]         fm_left,
    input  logic [15:0]         fm_right,
    input  logic signed [7:0]   pcm,
    input  logic [1:0]          fxlevel,
    input  logic                enable_fm,
    input  logic                enable_psg,
    output logic signed [15:0]  snd,
    output logic                peak
);

    logic [7:0]         fm_gain;
    logic [7:0]         pcm_gain;
    logic signed [24:0] left_prod;
    logic signed [24:0] right_prod;
    logic signed [16:0] pcm_prod;
    logic signed [26:0] mix_sum;
    logic signed [22:0] mix_shift;
    logic signed [15:0] mix_sat;
    logic               mix_over;

    assign fm_gain = enable_fm ? `SND_FM_GAIN : 8'h00;

    always_comb begin
        case (fxlevel)
            2'd0:    pcm_gain = `SND_PCM_GAIN0;
            2'd1:    pcm_gain = `SND_PCM_GAIN1;
            2'd2:    pcm_gain = `SND_PCM_GAIN2;
            default: pcm_gain = `SND_PCM_GAIN3;
        endcase
        if (!enable_psg) pcm_gain = 8'h00;
    end

    // Gains are unsigned 4.4, so a zero sign bit is prepended
    assign left_prod  = $signed(fm_left) * $signed({1'b0, fm_gain});
    assign right_prod = $signed(fm_right) * $signed({1'b0, fm_gain});
    assign pcm_prod   = pcm * $signed({1'b0, pcm_gain});
    assign mix_sum    = left_prod + right_prod + pcm_prod;
    assign mix_shift  = mix_sum[26:4];  // Drop the fraction

    always_comb begin
        mix_over = 1'b1;
        if (mix_shift > 23'sd32767) begin
            mix_sat = 16'sh7fff;
        end else if (mix_shift < -23'sd32768) begin
            mix_sat = 16'sh8000;
        end else begin
            mix_sat  = mix_shift[15:0];
            mix_over = 1'b0;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            snd  <= 16'sd0;
            peak <= 1'b0;
        end else if (fm_sample) begin
            snd  <= mix_sat;
            peak <= mix_over;  // Held until the next sample
        end
    end

endmodule

// File: design/sound_board.sv
`timescale 1ns/1ps
`include "snd_params.svh"

module sound_board (
    input  logic                   clk,
    input  logic                   rst,
    // Sound CPU bus
    input  logic [15:0]            addr,
    input  logic                   mreq_n,
    input  logic                   iorq_n,
    input  logic                   m1_n,
    input  logic                   rd_n,
    input  logic                   wr_n,
    input  logic [7:0]             cpu_dout,
    input  logic                   cen_snd,  // Clock enable of the external CPU
    output logic [7:0]             cpu_din,
    output logic                   cpu_rom_ok,
    output logic                   int_n,
    // Board options
    input  logic [7:0]             game_id,
    input  logic [1:0]             fxlevel,
    input  logic                   enable_fm,
    input  logic                   enable_psg,
    input  logic                   cen_pcm,
    // Main board mapper
    output logic                   mapper_rd,
    output logic                   mapper_wr,
    output logic [7:0]             mapper_din,
    input  logic [7:0]             mapper_dout,
    input  logic                   mapper_pbf,
    // Program ROM
    output logic                   rom_cs,
    output logic [`SND_ROM_AW-1:0] rom_addr,
    input  logic [7:0]             rom_data,
    input  logic                   rom_ok,
    // FM chip
    output logic                   fm_cs,
    output logic                   fm_a0,
    input  logic signed [15:0]     fm_left,
    input  logic signed [15:0]     fm_right,
    input  logic                   fm_sample,
    // Audio
    output logic signed [15:0]     snd,
    output logic                   peak
);
    import snd_pkg::*;

    rom_req_t          cpu_rom_req;
    rom_req_t          pcm_rom_req;
    logic              cpu_grant_ok;
    logic              pcm_grant_ok;
    logic              pcm_cs;
    logic              pcm_rst;
    logic              pcm_busy_n;
    logic signed [7:0] pcm_sample;

    assign int_n = ~mapper_pbf;  // Buffer full interrupts the CPU

    snd_decoder i_snd_decoder (
        .clk              ( clk          ),
        .rst              ( rst          ),
        .addr             ( addr         ),
        .mreq_n           ( mreq_n       ),
        .iorq_n           ( iorq_n       ),
        .m1_n             ( m1_n         ),
        .rd_n             ( rd_n         ),
        .wr_n             ( wr_n         ),
        .cpu_dout         ( cpu_dout     ),
        .game_id          ( game_id      ),
        .mapper_dout      ( mapper_dout  ),
        .pcm_busy_n       ( pcm_busy_n   ),
        .rom_data         ( rom_data     ),
        .cpu_rom_grant_ok ( cpu_grant_ok ),
        .cpu_din          ( cpu_din      ),
        .cpu_rom_req      ( cpu_rom_req  ),
        .cpu_rom_ok       ( cpu_rom_ok   ),
        .mapper_rd        ( mapper_rd    ),
        .mapper_wr        ( mapper_wr    ),
        .mapper_din       ( mapper_din   ),
        .fm_cs            ( fm_cs        ),
        .fm_a0            ( fm_a0        ),
        .pcm_cs           ( pcm_cs       ),
        .pcm_rst          ( pcm_rst      ),
        .pcm_mdn          (              )
    );

    rom_arbiter i_rom_arbiter (
        .clk      ( clk          ),
        .rst      ( rst          ),
        .cpu_req  ( cpu_rom_req  ),
        .pcm_req  ( pcm_rom_req  ),
        .rom_data ( rom_data     ),
        .rom_ok   ( rom_ok       ),
        .rom_cs   ( rom_cs       ),
        .rom_addr ( rom_addr     ),
        .cpu_ok   ( cpu_grant_ok ),
        .pcm_ok   ( pcm_grant_ok )
    );

    pcm_player i_pcm_player (
        .clk      ( clk          ),
        .rst      ( rst          ),
        .pcm_rst  ( pcm_rst      ),
        .cen_pcm  ( cen_pcm      ),
        .cs       ( pcm_cs       ),
        .wr_n     ( wr_n         ),
        .din      ( cpu_dout     ),
        .rom_data ( rom_data     ),
        .rom_ok   ( pcm_grant_ok ),
        .rom_req  ( pcm_rom_req  ),
        .busy_n   ( pcm_busy_n   ),
        .sample   ( pcm_sample   )
    );

    snd_mixer i_snd_mixer (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .fm_sample  ( fm_sample  ),
        .fm_left    ( fm_left    ),
        .fm_right   ( fm_right   ),
        .pcm        ( pcm_sample ),
        .fxlevel    ( fxlevel    ),
        .enable_fm  ( enable_fm  ),
        .enable_psg ( enable_psg ),
        .snd        ( snd        ),
        .peak       ( peak       )
    );

endmodule

// File: test/tb_sound_board.sv
`timescale 1ns/1ps
`include "snd_params.svh"

module tb_sound_board;
    import snd_pkg::*;

    logic                   clk, rst;
    logic [15:0]            addr;
    logic                   mreq_n, iorq_n, m1_n, rd_n, wr_n, cen_snd;
    logic [7:0]             cpu_dout, cpu_din;
    logic                   cpu_rom_ok, int_n;
    logic [7:0]             game_id;
    logic [1:0]             fxlevel;
    logic                   enable_fm, enable_psg, cen_pcm;
    logic                   mapper_rd, mapper_wr, mapper_pbf;
    logic [7:0]             mapper_din, mapper_dout;
    logic                   rom_cs, rom_ok;
    logic [`SND_ROM_AW-1:0] rom_addr;
    logic [7:0]             rom_data;
    logic                   fm_cs, fm_a0, fm_sample, peak;
    logic signed [15:0]     fm_left, fm_right, snd;

    logic [19:0]            steps [0:5*64-1];  // op, addr, data, lat, exp per step
    logic [7:0]             pcm_tab [0:255];
    logic [`SND_ROM_AW-1:0] pcm_addr_log [0:63];
    logic [`SND_ROM_AW-1:0] cpu_addr, prev_addr;
    logic                   prev_cs, prev_cpu_ok;
    logic                   pcm_playing;
    int                     nsteps, pcm_count, rom_lat, lat_cnt;
    logic [31:0]            seed_val;

    sound_board i_sound_board (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // PCM rate strobe pulses once every 24 clocks
    initial begin
        cen_pcm = 1'b0;
        forever begin
            repeat (23) @(posedge clk);
            #1 cen_pcm = 1'b1;
            @(posedge clk);
            #1 cen_pcm = 1'b0;
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [7:0] rom_byte(input logic [`SND_ROM_AW-1:0] a);
        if (a >= `SND_PCM_BASE)
            return pcm_tab[a[7:0]];  // Sample area comes from the table
        return a[7:0] ^ a[15:8];
    endfunction

    // ROM model answers after a per-step latency and holds ok until cs drops
    always @(posedge clk) begin
        #1;
        if (!rom_cs) begin
            lat_cnt = 0;
            rom_ok  = 1'b0;
        end else if (lat_cnt >= rom_lat) begin
            rom_ok   = 1'b1;
            rom_data = rom_byte(rom_addr);
        end else begin
            lat_cnt++;
        end
    end

    // Sorts completed ROM accesses into CPU and PCM
    always @(negedge clk) begin
        if (!rst) begin
            check_value(int_n, !mapper_pbf, "int_n vs mapper_pbf");
            check_value(fm_cs, !iorq_n && m1_n && addr[7:6] == `SND_IO_FM, "fm_cs decode");
            check_value(fm_a0, addr[0], "fm_a0 follows address bit 0");
            if (prev_cs && !rom_cs) begin
                if (cpu_rom_ok && !prev_cpu_ok) begin
                    cpu_addr = prev_addr;
                end else begin
                    pcm_addr_log[pcm_count] = prev_addr;
                    pcm_count++;
                end
            end
        end
        prev_cs     = rom_cs;
        prev_addr   = rom_addr;
        prev_cpu_ok = cpu_rom_ok;
    end

    task automatic release_bus();
        addr   = 16'h0000;
        mreq_n = 1'b1;
        iorq_n = 1'b1;
        rd_n   = 1'b1;
        wr_n   = 1'b1;
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d, input logic is_io,
                             output logic wr_seen);
        @(posedge clk);
        #1;
        addr     = a;
        cpu_dout = d;
        iorq_n   = !is_io;
        mreq_n   = is_io;
        wr_n     = 1'b0;
        @(negedge clk);
        wr_seen = mapper_wr;
        check_value(mapper_din, d, "mapper_din follows cpu_dout");
        @(posedge clk);
        #1 release_bus();
    endtask

    task automatic bus_read(input logic [15:0] a, input logic is_io, output logic [7:0] din,
                            output logic rd_seen);
        @(posedge clk);
        #1;
        addr   = a;
        iorq_n = !is_io;
        mreq_n = is_io;
        rd_n   = 1'b0;
        @(posedge clk);
        @(negedge clk);
        din     = cpu_din;
        rd_seen = mapper_rd;
        @(posedge clk);
        #1 release_bus();
    endtask

    task automatic rom_read(input logic [15:0] a, output logic [7:0] din);
        @(posedge clk);
        #1;
        addr   = a;
        mreq_n = 1'b0;
        rd_n   = 1'b0;
        @(negedge clk);
        while (!cpu_rom_ok) @(negedge clk);
        din = cpu_din;
        @(posedge clk);
        #1 release_bus();
    endtask

    task automatic mix_step(input logic [15:0] l, input logic [15:0] r, input logic [3:0] ctl,
                            input logic [16:0] exp);
        wait (pcm_count > 0);
        @(posedge clk);
        #1;
        fm_left    = l;
        fm_right   = r;
        enable_fm  = ctl[3];
        enable_psg = ctl[2];
        fxlevel    = ctl[1:0];
        repeat ($urandom % 4) @(posedge clk);
        #1 fm_sample = 1'b1;
        @(posedge clk);
        #1 fm_sample = 1'b0;
        @(negedge clk);
        check_value({peak, snd}, exp, "mixer output {peak, snd}");
    endtask

    initial begin
        logic [19:0] op, a, d, lat, exp;
        logic [7:0]  din;
        logic        seen;
        seed_val = $urandom(32'hebed);
        rst = 1'b1;
        release_bus();
        m1_n = 1'b1;
        cen_snd = 1'b1;
        cpu_dout = 8'h00;
        game_id = 8'h00;
        {fxlevel, enable_fm, enable_psg} = 4'b0000;
        mapper_dout = 8'h00;
        mapper_pbf = 1'b0;
        rom_ok = 1'b0;
        rom_data = 8'h00;
        {fm_left, fm_right, fm_sample} = '0;
        rom_lat = 0;
        lat_cnt = 0;
        pcm_count = 0;
        pcm_playing = 1'b0;
        for (int i = 0; i < 256; i++) pcm_tab[i] = 8'h00;
        $readmemh("test/snd_testdata.txt", steps);
        nsteps = 0;
        while (nsteps < 64 && !$isunknown(steps[5*nsteps])) nsteps++;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        for (int s = 0; s < nsteps; s++) begin
            op  = steps[5*s];
            a   = steps[5*s+1];
            d   = steps[5*s+2];
            lat = steps[5*s+3];
            exp = steps[5*s+4];
            mapper_pbf = s[0];
            if (op != 8) rom_lat = lat;
            case (op)
                0: game_id = d[7:0];
                1: begin
                    bus_write(a[15:0], d[7:0], 1'b1, seen);
                    if (a[7:6] == `SND_IO_PCM) pcm_playing = 1'b1;
                end
                2: begin
                    if (pcm_playing) @(posedge rom_cs);  // Read collides with a PCM fetch
                    rom_read(a[15:0], din);
                    check_value(cpu_addr, exp, "ROM address of CPU read");
                    check_value(din, exp[7:0] ^ exp[15:8], "CPU ROM byte");
                end
                3, 5: begin
                    mapper_dout = d[7:0];
                    bus_read(a[15:0], op == 3, din, seen);
                    check_value(din, exp[7:0], "read data");
                    check_value(seen, op == 5 || a[7:6] == `SND_IO_MAPPER, "mapper_rd");
                end
                4: begin
                    bus_write(a[15:0], d[7:0], 1'b0, seen);
                    check_value(seen, 1'b1, "mapper_wr during write");
                    @(negedge clk);
                    check_value(mapper_wr, 1'b0, "mapper_wr after write");
                end
                7: pcm_tab[a[7:0]] = d[7:0];
                8: mix_step(a[15:0], d[15:0], lat[3:0], exp[16:0]);
                9: begin
                    din = 8'h00;
                    while (!din[7]) bus_read({8'h00, `SND_IO_PCM, 6'h00}, 1'b1, din, seen);
                    pcm_playing = 1'b0;
                    check_value(pcm_count, exp, "PCM fetch count");
                    for (int i = 0; i < pcm_count; i++) begin
                        check_value(pcm_addr_log[i], `SND_PCM_BASE + d * 256 + i,
                                    "PCM fetch address");
                    end
                end
                default: check_value(op, 0, "unknown operation in data file");
            endcase
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    // Watchdog scaled by the number of steps
    initial begin
        wait (nsteps > 0);
        #(nsteps * 200 * 8);
        $display("Timeout: the run did not finish in %0d cycles", nsteps * 200);
        $display("SIMULATION FAILED");
        $fatal(1);
    end

endmodule

// File: test/snd_testdata.txt
// op addr data lat exp, all hex. op: 0 game_id, 1 I/O write, 2 ROM read, 3 I/O read,
// 4 mapper write, 5 mapper read, 7 PCM table, 8 mixer (l r ctl exp), 9 PCM end
0 0 00 0 0
1 40 05 0 0
2 9234 0 2 25234
0 0 20 0 0
1 40 16 0 0
2 c001 0 0 48001
0 0 10 0 0
1 40 2e 0 0
2 a5b4 0 5 3a5b4
2 1357 0 1 1357
3 40 0 0 ff
3 c0 5a 0 5a
3 80 0 0 ff
4 e800 3c 0 0
5 e900 a7 0 a7
7 0 c0 0 0
7 1 c0 0 0
7 2 c0 0 0
7 3 c0 0 0
7 4 90 0 0
7 5 a1 0 0
1 40 40 0 0
1 80 03 1 0
8 0 0 f 50
8 0 0 d 10
8 7fff 7fff f 17fff
8 7fff 7fff 7 50
8 1000 200 b 900
8 8000 8000 f 8050
2 1357 0 3 1357
3 80 0 0 7f
9 0 03 1 7
8 0 0 f 0

// File: filelist.f
+incdir+common
common/snd_pkg.sv
design/snd_decoder.sv
design/rom_arbiter.sv
pcm/pcm_player.sv
design/snd_mixer.sv
design/sound_board.sv
test/tb_sound_board.sv

// File: Bender.yml
package:
  name: sound_board

sources:
  - include_dirs:
      - common
    files:
      - common/snd_pkg.sv
      - design/snd_decoder.sv
      - design/rom_arbiter.sv
      - pcm/pcm_player.sv
      - design/snd_mixer.sv
      - design/sound_board.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/tb_sound_board.sv
